// ==== logic/sd_dat_pkg.sv ====
`default_nettype none

package sd_dat_pkg;

    // ========================================================================
    // Data path widths
    // ========================================================================
    localparam int WORD_W           = 16;   // One SD data-in word
    localparam int NIBBLE_W         = 4;    // Quad-lane readout group
    localparam int NIBBLES_PER_WORD = WORD_W / NIBBLE_W;

    // ========================================================================
    // SD block geometry and CMD6 status layout
    // ========================================================================
    // 512-bit block carried as 16-bit words
    localparam int BLOCK_WORDS      = 512 / WORD_W;

    // Access-mode field of the CMD6 switch status
    localparam int ACCESS_MODE_WORD = 8;    // Zero-based word within the block
    localparam int ACCESS_MODE_LSB  = 8;
    localparam int ACCESS_MODE_W    = 4;

    // ========================================================================
    // Types
    // ========================================================================
    typedef logic [WORD_W-1:0]        data_word_t;
    typedef logic [NIBBLE_W-1:0]      nibble_t;
    typedef logic [ACCESS_MODE_W-1:0] access_mode_t;

    // Nibble readout FSM
    typedef enum logic [0:0] {
        RD_IDLE,    // Waiting for a word and rd_en
        RD_SHIFT    // Streaming nibbles of the loaded word
    } readout_state_t;

endpackage

`default_nettype wire

// ==== logic/block_word_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_word_writer (
    input  logic                     sd_datInWrite_clk,
    input  logic                     sd_datInWrite_rst_,
    input  logic                     dat_trigger,
    input  sd_dat_pkg::data_word_t   dat_data,
    output logic                     dat_ready,
    input  logic                     fifo_full,
    output logic                     fifo_push,
    output sd_dat_pkg::data_word_t   fifo_push_data,
    output sd_dat_pkg::access_mode_t cmd6_access_mode
);
    import sd_dat_pkg::*;

    localparam int IDX_W = $clog2(BLOCK_WORDS);

    logic [IDX_W-1:0] word_idx;     // Position of the next word within its block
    logic             word_accept;
    logic             block_last;
    logic             mode_word;

    // ========================================================================
    // Handshake toward the data source
    // ========================================================================
    assign dat_ready   = !fifo_full;
    // A trigger against a full FIFO is dropped
    assign word_accept = dat_trigger && !fifo_full;

    // Words go into the FIFO untouched
    assign fifo_push      = word_accept;
    assign fifo_push_data = dat_data;

    assign block_last = (word_idx == IDX_W'(BLOCK_WORDS - 1));
    assign mode_word  = (word_idx == IDX_W'(ACCESS_MODE_WORD));

    // ========================================================================
    // Block word counter
    // ========================================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_idx <= '0;                 // Start of a block
        end else if (word_accept) begin
            if (block_last) begin
                word_idx <= '0;
            end else begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    // ========================================================================
    // CMD6 access-mode capture
    // ========================================================================
    // Switch status arrives as a 512-bit block; only one field is kept,
    // refreshed by every block that passes through
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            cmd6_access_mode <= '0;
        end else if (word_accept && mode_word) begin
            cmd6_access_mode <= dat_data[ACCESS_MODE_LSB +: ACCESS_MODE_W];
        end
    end

endmodule

`default_nettype wire

// ==== logic/word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
    parameter int FIFO_DEPTH = 64       // Power of two, at least 4
) (
    input  logic                   sd_datInWrite_clk,
    input  logic                   sd_datInWrite_rst_,
    input  logic                   fifo_push,
    input  sd_dat_pkg::data_word_t fifo_push_data,
    input  logic                   fifo_pop,
    output sd_dat_pkg::data_word_t fifo_head,
    output logic                   fifo_full,
    output logic                   fifo_empty
);
    import sd_dat_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    // ========================================================================
    // Storage and pointers
    // ========================================================================
    data_word_t  mem [FIFO_DEPTH];

    // Extra top bit tells a full FIFO from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic        do_push;
    logic        do_pop;
    logic        ptr_wrapped;       // Pointers on different laps
    logic        addr_match;

    assign ptr_wrapped = (wr_ptr[AW] != rd_ptr[AW]);
    assign addr_match  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign fifo_empty = !ptr_wrapped && addr_match;
    assign fifo_full  = ptr_wrapped && addr_match;

    // Requests against a full or empty FIFO are ignored
    assign do_push = fifo_push && !fifo_full;
    assign do_pop  = fifo_pop && !fifo_empty;

    // Oldest word sits on the output with no read latency
    assign fifo_head = mem[rd_ptr[AW-1:0]];

    // ========================================================================
    // Write side
    // ========================================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= fifo_push_data;
        end
    end

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // ========================================================================
    // Read side
    // ========================================================================
    // Head advances on the same edge that takes the pop;
    // a push in that cycle lands independently
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/nibble_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_readout (
    input  logic                   sd_datInWrite_clk,
    input  logic                   sd_datInWrite_rst_,
    input  logic                   rd_en,
    input  logic                   fifo_empty,
    input  sd_dat_pkg::data_word_t fifo_head,
    output logic                   fifo_pop,
    output logic                   nibble_valid,
    output sd_dat_pkg::nibble_t    nibble_data
);
    import sd_dat_pkg::*;

    localparam int CNT_W = $clog2(NIBBLES_PER_WORD);

    readout_state_t   state_q;
    readout_state_t   state_d;
    data_word_t       shift_q;      // Word being streamed, MSB nibble on top
    logic [CNT_W-1:0] nib_cnt;      // Nibbles already presented from shift_q
    logic             shift_en;
    logic             last_nibble;
    logic             load_word;

    // ========================================================================
    // Control
    // ========================================================================
    // rd_en low freezes everything
    assign shift_en    = (state_q == RD_SHIFT) && rd_en;
    assign last_nibble = (nib_cnt == CNT_W'(NIBBLES_PER_WORD - 1));

    // Fetch from idle, or chain the next word on the last nibble
    assign load_word = rd_en && !fifo_empty
                       && ((state_q == RD_IDLE) || (shift_en && last_nibble));

    assign fifo_pop = load_word;    // FIFO drops its head on the same edge

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                if (load_word) begin
                    state_d = RD_SHIFT;
                end
            end
            RD_SHIFT: begin
                // Word done and nothing queued behind it
                if (shift_en && last_nibble && !load_word) begin
                    state_d = RD_IDLE;
                end
            end
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state_q      <= RD_IDLE;
            nib_cnt      <= '0;
            nibble_valid <= 1'b0;
        end else begin
            state_q      <= state_d;
            nibble_valid <= shift_en;   // One nibble per enabled shift cycle
            if (load_word) begin
                nib_cnt <= '0;
            end else if (shift_en) begin
                nib_cnt <= nib_cnt + 1'b1;
            end
        end
    end

    // ========================================================================
    // Shift register and nibble output
    // ========================================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (load_word) begin
            shift_q <= fifo_head;
        end else if (shift_en) begin
            shift_q <= shift_q << NIBBLE_W;
        end

        // On a chained load this still takes the last nibble of the old word
        if (shift_en) begin
            nibble_data <= shift_q[WORD_W-1 -: NIBBLE_W];
        end
    end

endmodule

`default_nettype wire

// ==== logic/sd_data_in_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_data_in_path #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                     sd_datInWrite_clk,
    input  logic                     sd_datInWrite_rst_,
    input  logic                     dat_trigger,
    input  sd_dat_pkg::data_word_t   dat_data,
    output logic                     dat_ready,
    input  logic                     rd_en,
    output logic                     nibble_valid,
    output sd_dat_pkg::nibble_t      nibble_data,
    output sd_dat_pkg::access_mode_t cmd6_access_mode
);
    import sd_dat_pkg::*;

    // Writer to FIFO
    logic       fifo_push;
    data_word_t fifo_push_data;
    logic       fifo_full;

    // FIFO to readout
    logic       fifo_empty;
    data_word_t fifo_head;
    logic       fifo_pop;

    // ========================================================================
    // Data-in write port
    // ========================================================================
    block_word_writer u_block_word_writer (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .dat_trigger        (dat_trigger),
        .dat_data           (dat_data),
        .dat_ready          (dat_ready),
        .fifo_full          (fifo_full),
        .fifo_push          (fifo_push),
        .fifo_push_data     (fifo_push_data),
        .cmd6_access_mode   (cmd6_access_mode)
    );

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_word_fifo (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .fifo_push          (fifo_push),
        .fifo_push_data     (fifo_push_data),
        .fifo_pop           (fifo_pop),
        .fifo_head          (fifo_head),
        .fifo_full          (fifo_full),
        .fifo_empty         (fifo_empty)
    );

    // ========================================================================
    // Quad-lane readout
    // ========================================================================
    nibble_readout u_nibble_readout (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .rd_en              (rd_en),
        .fifo_empty         (fifo_empty),
        .fifo_head          (fifo_head),
        .fifo_pop           (fifo_pop),
        .nibble_valid       (nibble_valid),
        .nibble_data        (nibble_data)
    );

endmodule

`default_nettype wire

// ==== tests/sd_data_in_path_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_data_in_path_sva (
    input logic sd_datInWrite_clk,
    input logic sd_datInWrite_rst_,
    input logic dat_trigger,
    input logic dat_ready,
    input logic rd_en,
    input logic nibble_valid
);

    // Source may only trigger while the FIFO has room
    trigger_needs_ready: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        dat_trigger |-> dat_ready
    ) else $error("dat_trigger asserted while dat_ready was low");

    // A stalled readout presents nothing
    stall_blocks_valid: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        !$past(rd_en) |-> !nibble_valid
    ) else $error("nibble_valid high after a cycle with rd_en low");

    leave_reset_idle: assert property (
        @(posedge sd_datInWrite_clk)
        $rose(sd_datInWrite_rst_) |-> (dat_ready && !nibble_valid)
    ) else $error("dat_ready or nibble_valid wrong on reset release");

endmodule

bind sd_data_in_path sd_data_in_path_sva u_sd_data_in_path_sva (
    .sd_datInWrite_clk  (sd_datInWrite_clk),
    .sd_datInWrite_rst_ (sd_datInWrite_rst_),
    .dat_trigger        (dat_trigger),
    .dat_ready          (dat_ready),
    .rd_en              (rd_en),
    .nibble_valid       (nibble_valid)
);

`default_nettype wire

// ==== tests/tb_sd_data_in_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sd_data_in_path;
    import sd_dat_pkg::*;

    // ========================================================================
    // Run geometry
    // ========================================================================
    localparam int FIFO_DEPTH   = 8;
    localparam int CLK_HALF     = 50;
    localparam int DRIVE_DELAY  = 5;    // Inputs change this long after the edge
    localparam int RESET_CYCLES = 8;

    localparam int N_ORDER  = 40;
    localparam int N_RANDOM = 60;
    localparam int N_BLOCKS = 3;

    // Padding to a block boundary costs at most one extra block
    localparam int TOTAL_WORDS     = N_ORDER + FIFO_DEPTH + N_RANDOM
                                     + (N_BLOCKS + 1) * BLOCK_WORDS;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * NIBBLES_PER_WORD * 4 + 1000;

    logic         sd_datInWrite_clk;
    logic         sd_datInWrite_rst_;
    logic         dat_trigger;
    data_word_t   dat_data;
    logic         dat_ready;
    logic         rd_en;
    logic         nibble_valid;
    nibble_t      nibble_data;
    access_mode_t cmd6_access_mode;

    nibble_t      exp_q[$];         // Nibbles still owed by the readout
    data_word_t   sent_words[$];    // Every accepted word since reset
    logic         rd_random;        // Randomize rd_en on each cycle

    sd_data_in_path #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_sd_data_in_path (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .dat_trigger        (dat_trigger),
        .dat_data           (dat_data),
        .dat_ready          (dat_ready),
        .rd_en              (rd_en),
        .nibble_valid       (nibble_valid),
        .nibble_data        (nibble_data),
        .cmd6_access_mode   (cmd6_access_mode)
    );

    always #CLK_HALF sd_datInWrite_clk = ~sd_datInWrite_clk;

    // ========================================================================
    // Reference model
    // ========================================================================
    // Nibble k of a word counted from the most significant end
    function automatic nibble_t word_nibble(input data_word_t w, input int k);
        return nibble_t'(w >> (NIBBLE_W * (NIBBLES_PER_WORD - 1 - k)));
    endfunction

    // Field of the latest word that sat at the access-mode slot of its block
    function automatic access_mode_t expected_access_mode();
        access_mode_t mode;
        mode = '0;
        for (int i = 0; i < sent_words.size(); i++) begin
            if ((i % BLOCK_WORDS) == ACCESS_MODE_WORD) begin
                mode = access_mode_t'(sent_words[i] >> ACCESS_MODE_LSB);
            end
        end
        return mode;
    endfunction

    // ========================================================================
    // Failure handling and compare tasks
    // ========================================================================
    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_nibble(input nibble_t exp, input nibble_t act);
        if (act !== exp) begin
            $display("Error at time %0t: nibble_data expected %h, got %h", $time, exp, act);
            abort_run();
        end
    endtask

    task automatic check_access_mode(input access_mode_t exp, input access_mode_t act);
        if (act !== exp) begin
            $display("Error at time %0t: cmd6_access_mode expected %h, got %h",
                     $time, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Output side checker
    always @(posedge sd_datInWrite_clk) begin
        if (sd_datInWrite_rst_ && nibble_valid) begin
            if (exp_q.size() == 0) begin
                $display("Readout presented a nibble that was never sent");
                abort_run();
            end else begin
                check_nibble(exp_q.pop_front(), nibble_data);
            end
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sd_datInWrite_clk);
        $display("Readout stalled, %0d nibbles still pending after %0d cycles",
                 exp_q.size(), WATCHDOG_CYCLES);
        abort_run();
    end

    // ========================================================================
    // Stimulus helpers
    // ========================================================================
    task automatic step_cycle();
        @(posedge sd_datInWrite_clk);
        #DRIVE_DELAY;
        if (rd_random) begin
            rd_en = ($urandom() % 2) == 0;
        end
    endtask

    task automatic apply_reset();
        sd_datInWrite_rst_ = 1'b0;
        repeat (RESET_CYCLES) @(posedge sd_datInWrite_clk);
        #DRIVE_DELAY;
        sd_datInWrite_rst_ = 1'b1;
        step_cycle();
    endtask

    task automatic send_word(input data_word_t w);
        while (!dat_ready) begin
            step_cycle();
        end
        dat_trigger = 1'b1;
        dat_data    = w;
        step_cycle();                   // Accepted on this edge
        dat_trigger = 1'b0;
        sent_words.push_back(w);
        for (int k = 0; k < NIBBLES_PER_WORD; k++) begin
            exp_q.push_back(word_nibble(w, k));
        end
        check_access_mode(expected_access_mode(), cmd6_access_mode);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            step_cycle();
        end
    endtask

    // ========================================================================
    // Test sequences
    // ========================================================================
    task automatic verify_reset_state();
        check_bit("dat_ready", 1'b1, dat_ready);
        check_bit("nibble_valid", 1'b0, nibble_valid);
        check_access_mode('0, cmd6_access_mode);
    endtask

    task automatic stream_in_order();
        rd_en = 1'b1;
        for (int n = 0; n < N_ORDER; n++) begin
            send_word(data_word_t'($urandom()));
        end
        wait_drained();
    endtask

    // FIFO must take exactly its depth while the output is stalled
    task automatic fill_while_stalled();
        int accepted;
        accepted = 0;
        rd_en    = 1'b0;
        while (dat_ready && accepted < FIFO_DEPTH + 4) begin
            send_word(data_word_t'($urandom()));
            accepted++;
        end
        if (accepted != FIFO_DEPTH) begin
            $display("Error at time %0t: accepted words expected %0d, got %0d",
                     $time, FIFO_DEPTH, accepted);
            abort_run();
        end
        repeat (4) step_cycle();
        rd_en = 1'b1;
        wait_drained();
    endtask

    task automatic stream_with_stalls();
        int gap;
        rd_random = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            gap = int'($urandom_range(3, 0));
            repeat (gap) step_cycle();
            send_word(data_word_t'($urandom()));
        end
        rd_random = 1'b0;
        rd_en     = 1'b1;
        wait_drained();
    endtask

    task automatic capture_access_modes();
        access_mode_t base;
        access_mode_t mode;
        data_word_t   w;
        rd_en = 1'b1;
        while ((sent_words.size() % BLOCK_WORDS) != 0) begin
            send_word(data_word_t'($urandom()));
        end
        base = expected_access_mode();
        for (int b = 0; b < N_BLOCKS; b++) begin
            mode = access_mode_t'(base + access_mode_t'(3 + 4 * b));   // Distinct per block
            for (int i = 0; i < BLOCK_WORDS; i++) begin
                w = data_word_t'($urandom());
                if (i == ACCESS_MODE_WORD) begin
                    w[ACCESS_MODE_LSB +: ACCESS_MODE_W] = mode;
                end
                send_word(w);
            end
            check_access_mode(mode, cmd6_access_mode);
        end
        wait_drained();
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        void'($urandom(32'h5d38));
        sd_datInWrite_clk  = 1'b0;
        sd_datInWrite_rst_ = 1'b0;
        dat_trigger        = 1'b0;
        dat_data           = '0;
        rd_en              = 1'b0;
        rd_random          = 1'b0;

        apply_reset();
        verify_reset_state();
        stream_in_order();
        fill_while_stalled();
        stream_with_stalls();
        capture_access_modes();
        repeat (10) step_cycle();       // Catch any stray nibble

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/sd_dat_pkg.sv
logic/block_word_writer.sv
logic/word_fifo.sv
logic/nibble_readout.sv
logic/sd_data_in_path.sv
tests/sd_data_in_path_sva.sv
tests/tb_sd_data_in_path.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_sd_data_in_path

verilator --binary --timing --assert \
    --top-module tb_sd_data_in_path \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run ended with status $status"
    exit $status
fi

echo "Simulation run ended cleanly"
exit 0
